// ==== logic/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and instruction width
`define CPU_WORD_W 16

// architectural register count, register 0 reads zero
`define CPU_REG_CNT 16

// pc advance per instruction in bytes
`define CPU_PC_STEP 2

// add r0, r0, r0 doubles as the pipeline bubble
`define CPU_NOP 16'h0000

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    `include "cpu_defines.svh"

    // one machine word, used for data, instructions and addresses
    typedef logic [`CPU_WORD_W-1:0] word_t;

    // register number
    typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_addr_t;

    // top nibble of the instruction
    // 0011 and 0111 are unassigned and run as no-ops
    typedef enum logic [3:0] {
        OP_ADD = 4'b0000,
        OP_SUB = 4'b0001,
        OP_XOR = 4'b0010,
        OP_SLL = 4'b0100,
        OP_SRA = 4'b0101,
        OP_ROR = 4'b0110,
        OP_LW  = 4'b1000,
        OP_SW  = 4'b1001,
        OP_LLB = 4'b1010,
        OP_LHB = 4'b1011,
        OP_B   = 4'b1100,
        OP_HLT = 4'b1111
    } opcode_e;

    // branch condition in bits 11:9 of a branch
    typedef enum logic [2:0] {
        COND_NE     = 3'b000,
        COND_EQ     = 3'b001,
        COND_GT     = 3'b010,
        COND_LT     = 3'b011,
        COND_GE     = 3'b100,
        COND_LE     = 3'b101,
        COND_OV     = 3'b110,
        COND_ALWAYS = 3'b111
    } cond_e;

    // zero, signed overflow, negative
    typedef struct packed {
        logic z;
        logic v;
        logic n;
    } flags_t;

endpackage

`default_nettype wire

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module instr_decode import cpu_pkg::*; (
    input  word_t     instr,
    output opcode_e   opcode,
    output reg_addr_t rd,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output word_t     imm,
    output logic      reg_write,
    output logic      mem_read,
    output logic      mem_write,
    output logic      use_imm,
    output logic      byte_load,
    output logic      is_branch,
    output logic      is_halt
);

    logic bubble;
    logic alu_op;
    logic shift_op;
    logic mem_op;

    assign opcode = opcode_e'(instr[15:12]);

    // the nop word is an add to r0, treated as a bubble
    assign bubble = (instr == `CPU_NOP);

    assign alu_op   = opcode inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR};
    assign shift_op = opcode inside {OP_SLL, OP_SRA, OP_ROR};
    assign mem_op   = opcode inside {OP_LW, OP_SW};

    assign byte_load = opcode inside {OP_LLB, OP_LHB};
    assign mem_read  = (opcode == OP_LW);
    assign mem_write = (opcode == OP_SW);
    assign is_branch = (opcode == OP_B);
    assign is_halt   = (opcode == OP_HLT);

    // shifts take a 4-bit amount, memory ops an offset, byte loads a byte
    assign use_imm = shift_op | mem_op | byte_load;

    // unassigned opcodes, branches and halts write nothing
    assign reg_write = (alu_op & ~bubble) | mem_read | byte_load;

    assign rd = instr[11:8];
    // byte loads read their own destination to keep the other byte
    assign rs = byte_load ? instr[11:8] : instr[7:4];
    // store data register sits where a load's destination would be
    assign rt = mem_write ? instr[11:8] : instr[3:0];

    always_comb begin
        if (mem_op) begin
            // halfword offset, sign extended
            imm = {{(`CPU_WORD_W-5){instr[3]}}, instr[3:0], 1'b0};
        end else if (byte_load) begin
            imm = {{(`CPU_WORD_W-8){1'b0}}, instr[7:0]};
        end else begin
            imm = {{(`CPU_WORD_W-4){1'b0}}, instr[3:0]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/branch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module branch_control import cpu_pkg::*; (
    input  word_t  instr,
    input  word_t  pc_plus,
    input  flags_t flags,
    input  logic   is_branch,
    output logic   branch_taken,
    output word_t  branch_target
);

    cond_e cond;
    word_t offset;
    logic  cond_met;

    assign cond = cond_e'(instr[11:9]);

    // 9-bit signed instruction offset, relative to the next pc
    assign offset        = {{(`CPU_WORD_W-10){instr[8]}}, instr[8:0], 1'b0};
    assign branch_target = pc_plus + offset;

    always_comb begin
        case (cond)
            COND_NE:     cond_met = ~flags.z;
            COND_EQ:     cond_met = flags.z;
            COND_GT:     cond_met = ~flags.z & ~flags.n;
            COND_LT:     cond_met = flags.n;
            COND_GE:     cond_met = flags.z | ~flags.n;
            COND_LE:     cond_met = flags.z | flags.n;
            COND_OV:     cond_met = flags.v;
            default:     cond_met = 1'b1;
        endcase
    end

    assign branch_taken = is_branch & cond_met;

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module register_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  reg_addr_t rd,
    input  word_t     rd_data,
    input  logic      reg_write,
    input  flags_t    flags_in,
    input  flags_t    flags_en,
    output word_t     rs_data,
    output word_t     rt_data,
    output flags_t    flags
);

    word_t  regs [`CPU_REG_CNT];
    flags_t flags_q;
    logic   wr_live;

    // r0 is cleared by reset and never written after
    assign wr_live = reg_write && (rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd] <= rd_data;
        end
    end

    // each flag only moves when its own enable is set
    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q <= '0;
        end else begin
            if (flags_en.z) begin
                flags_q.z <= flags_in.z;
            end
            if (flags_en.v) begin
                flags_q.v <= flags_in.v;
            end
            if (flags_en.n) begin
                flags_q.n <= flags_in.n;
            end
        end
    end

    // write-back in the same cycle is visible to decode
    assign rs_data = (wr_live && rd == rs) ? rd_data : regs[rs];
    assign rt_data = (wr_live && rd == rt) ? rd_data : regs[rt];
    assign flags   = flags_q;

    assert property (@(posedge clk) disable iff (reset) (rs == '0) |-> (rs_data == '0))
        else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  opcode_e op,
    output word_t   result,
    output flags_t  flags_out,
    output flags_t  flags_en
);

    word_t                    sum;
    word_t                    diff;
    logic [3:0]               shamt;
    logic [2*`CPU_WORD_W-1:0] rot;
    logic                     sum_ovf;
    logic                     diff_ovf;

    assign shamt = b[3:0];
    assign sum   = a + b;
    assign diff  = a - b;
    // rotate right as a shift of the doubled word
    assign rot   = {a, a} >> shamt;

    // signed overflow: operand signs vs result sign
    assign sum_ovf  = (a[`CPU_WORD_W-1] == b[`CPU_WORD_W-1]) &&
                      (sum[`CPU_WORD_W-1] != a[`CPU_WORD_W-1]);
    assign diff_ovf = (a[`CPU_WORD_W-1] != b[`CPU_WORD_W-1]) &&
                      (diff[`CPU_WORD_W-1] != a[`CPU_WORD_W-1]);

    always_comb begin
        result      = '0;
        flags_en    = '0;
        flags_out.v = 1'b0;
        case (op)
            OP_ADD: begin
                result      = sum;
                flags_out.v = sum_ovf;
                flags_en    = 3'b111;
            end
            OP_SUB: begin
                result      = diff;
                flags_out.v = diff_ovf;
                flags_en    = 3'b111;
            end
            OP_XOR: begin
                result     = a ^ b;
                flags_en.z = 1'b1;
            end
            OP_SLL: begin
                result     = a << shamt;
                flags_en.z = 1'b1;
            end
            OP_SRA: begin
                result     = word_t'($signed(a) >>> shamt);
                flags_en.z = 1'b1;
            end
            OP_ROR: begin
                result     = rot[`CPU_WORD_W-1:0];
                flags_en.z = 1'b1;
            end
            // base plus offset
            OP_LW, OP_SW: result = sum;
            // merged byte arrives on b
            OP_LLB, OP_LHB: result = b;
            default: result = '0;
        endcase
        flags_out.z = (result == '0);
        flags_out.n = result[`CPU_WORD_W-1];
    end

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  logic      id_is_branch,
    input  reg_addr_t ex_rs,
    input  reg_addr_t ex_rt,
    input  reg_addr_t ex_rd,
    input  reg_addr_t mem_rd,
    input  reg_addr_t wb_rd,
    input  logic      ex_reg_write,
    input  logic      ex_mem_read,
    input  logic      ex_sets_flags,
    input  logic      mem_reg_write,
    input  logic      mem_mem_write,
    input  reg_addr_t mem_rt,
    input  logic      wb_reg_write,
    output logic      fwd_ex_rs,
    output logic      fwd_ex_rt,
    output logic      fwd_mem_rs,
    output logic      fwd_mem_rt,
    output logic      fwd_store,
    output logic      stall
);

    logic mem_src;
    logic wb_src;
    logic load_use;
    logic flag_wait;

    // r0 results never forward
    assign mem_src = mem_reg_write && (mem_rd != '0);
    assign wb_src  = wb_reg_write && (wb_rd != '0);

    // the younger result in MEM wins over WB
    assign fwd_ex_rs  = mem_src && (mem_rd == ex_rs);
    assign fwd_ex_rt  = mem_src && (mem_rd == ex_rt);
    assign fwd_mem_rs = wb_src && (wb_rd == ex_rs) && !fwd_ex_rs;
    assign fwd_mem_rt = wb_src && (wb_rd == ex_rt) && !fwd_ex_rt;

    // store data in MEM taken from the instruction in WB
    assign fwd_store = mem_mem_write && wb_src && (wb_rd == mem_rt);

    // load data is not ready until it leaves MEM
    assign load_use = ex_mem_read && ex_reg_write && (ex_rd != '0) &&
                      ((ex_rd == id_rs) || (ex_rd == id_rt));

    // branch waits one cycle for flags being produced in EX
    assign flag_wait = id_is_branch && ex_sets_flags;

    assign stall = load_use | flag_wait;

    always_comb begin
        assert final (!(fwd_ex_rs && fwd_mem_rs))
            else $error("rs forwarded from MEM and WB at once");
    end

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t imem_rdata,
    input  word_t dmem_rdata,
    output word_t imem_addr,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    output logic  hlt,
    output word_t pc
);

    // fetch
    word_t     pc_q;
    word_t     if_pc_plus;
    logic      if_halt;

    // decode
    word_t     id_instr;
    word_t     id_pc_plus;
    opcode_e   id_opcode;
    reg_addr_t id_rd, id_rs, id_rt;
    word_t     id_imm, id_rs_data, id_rt_data;
    logic      id_reg_write, id_mem_read, id_mem_write;
    logic      id_use_imm, id_byte_load, id_is_branch, id_is_halt;
    logic      branch_taken;
    word_t     branch_target;
    flags_t    flags;

    // execute
    opcode_e   ex_opcode;
    reg_addr_t ex_rd, ex_rs, ex_rt;
    word_t     ex_imm, ex_rs_data, ex_rt_data;
    logic      ex_reg_write, ex_mem_read, ex_mem_write;
    logic      ex_use_imm, ex_byte_load, ex_sets_flags, ex_halt;
    word_t     ex_a, ex_rt_fwd, ex_merge, ex_b, ex_result;
    flags_t    alu_flags, alu_flags_en, ex_flags_en;

    // memory
    word_t     mem_result, mem_store_data;
    reg_addr_t mem_rd, mem_rt;
    logic      mem_reg_write, mem_mem_read, mem_mem_write, mem_halt;

    // write-back
    word_t     wb_result, wb_load_data, wb_data;
    reg_addr_t wb_rd;
    logic      wb_reg_write, wb_mem_read, wb_halt;

    logic      hlt_q;
    logic      stall;
    logic      fwd_ex_rs, fwd_ex_rt, fwd_mem_rs, fwd_mem_rt, fwd_store;

    assign if_pc_plus = pc_q + word_t'(`CPU_PC_STEP);
    // halt parks fetch on its own address
    assign if_halt    = (imem_rdata[15:12] == OP_HLT);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= '0;
        end else if (branch_taken) begin
            pc_q <= branch_target;
        end else if (!stall && !if_halt) begin
            pc_q <= if_pc_plus;
        end
    end

    // IF/ID, a taken branch drops the one instruction fetched behind it
    always_ff @(posedge clk) begin
        if (reset || branch_taken) begin
            id_instr <= `CPU_NOP;
        end else if (!stall) begin
            id_instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc_plus <= if_pc_plus;
        end
    end

    instr_decode i_decode (
        .instr     (id_instr),
        .opcode    (id_opcode),
        .rd        (id_rd),
        .rs        (id_rs),
        .rt        (id_rt),
        .imm       (id_imm),
        .reg_write (id_reg_write),
        .mem_read  (id_mem_read),
        .mem_write (id_mem_write),
        .use_imm   (id_use_imm),
        .byte_load (id_byte_load),
        .is_branch (id_is_branch),
        .is_halt   (id_is_halt)
    );

    // no redirect while stalled, flags may still be in flight
    branch_control i_branch (
        .instr         (id_instr),
        .pc_plus       (id_pc_plus),
        .flags         (flags),
        .is_branch     (id_is_branch && !stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    register_file i_regs (
        .clk       (clk),
        .reset     (reset),
        .rs        (id_rs),
        .rt        (id_rt),
        .rd        (wb_rd),
        .rd_data   (wb_data),
        .reg_write (wb_reg_write),
        .flags_in  (alu_flags),
        .flags_en  (ex_flags_en),
        .rs_data   (id_rs_data),
        .rt_data   (id_rt_data),
        .flags     (flags)
    );

    // ID/EX, stall slips a bubble in behind the held instruction
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_sets_flags <= 1'b0;
            ex_halt       <= 1'b0;
        end else begin
            ex_reg_write  <= id_reg_write;
            ex_mem_read   <= id_mem_read;
            ex_mem_write  <= id_mem_write;
            // only ALU ops write flags, nop and no-op opcodes have reg_write low
            ex_sets_flags <= id_reg_write && !id_opcode[3];
            ex_halt       <= id_is_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_opcode    <= id_opcode;
        ex_rd        <= id_rd;
        ex_rs        <= id_rs;
        ex_rt        <= id_rt;
        ex_imm       <= id_imm;
        ex_rs_data   <= id_rs_data;
        ex_rt_data   <= id_rt_data;
        ex_use_imm   <= id_use_imm;
        ex_byte_load <= id_byte_load;
    end

    // operands, forwarded values first
    assign ex_a      = fwd_ex_rs ? mem_result : (fwd_mem_rs ? wb_data : ex_rs_data);
    assign ex_rt_fwd = fwd_ex_rt ? mem_result : (fwd_mem_rt ? wb_data : ex_rt_data);

    // llb replaces the low byte, lhb the high byte
    assign ex_merge = (ex_opcode == OP_LHB) ? {ex_imm[7:0], ex_a[7:0]}
                                            : {ex_a[15:8], ex_imm[7:0]};
    assign ex_b     = ex_byte_load ? ex_merge : (ex_use_imm ? ex_imm : ex_rt_fwd);

    alu i_alu (
        .a         (ex_a),
        .b         (ex_b),
        .op        (ex_opcode),
        .result    (ex_result),
        .flags_out (alu_flags),
        .flags_en  (alu_flags_en)
    );

    assign ex_flags_en = ex_sets_flags ? alu_flags_en : flags_t'('0);

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_halt      <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_halt      <= ex_halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= ex_result;
        mem_store_data <= ex_rt_fwd;
        mem_rd         <= ex_rd;
        mem_rt         <= ex_rt;
    end

    assign dmem_addr  = mem_result;
    assign dmem_wdata = fwd_store ? wb_data : mem_store_data;
    assign dmem_we    = mem_mem_write;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_write <= 1'b0;
            wb_mem_read  <= 1'b0;
            wb_halt      <= 1'b0;
        end else begin
            wb_reg_write <= mem_reg_write;
            wb_mem_read  <= mem_mem_read;
            wb_halt      <= mem_halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_result    <= mem_result;
        wb_load_data <= dmem_rdata;
        wb_rd        <= mem_rd;
    end

    assign wb_data = wb_mem_read ? wb_load_data : wb_result;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            hlt_q <= 1'b0;
        end else if (wb_halt) begin
            hlt_q <= 1'b1;
        end
    end

    hazard_unit i_hazard (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_is_branch  (id_is_branch),
        .ex_rs         (ex_rs),
        .ex_rt         (ex_rt),
        .ex_rd         (ex_rd),
        .mem_rd        (mem_rd),
        .wb_rd         (wb_rd),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_sets_flags (ex_sets_flags),
        .mem_reg_write (mem_reg_write),
        .mem_mem_write (mem_mem_write),
        .mem_rt        (mem_rt),
        .wb_reg_write  (wb_reg_write),
        .fwd_ex_rs     (fwd_ex_rs),
        .fwd_ex_rt     (fwd_ex_rt),
        .fwd_mem_rs    (fwd_mem_rs),
        .fwd_mem_rt    (fwd_mem_rt),
        .fwd_store     (fwd_store),
        .stall         (stall)
    );

    assign imem_addr = pc_q;
    assign pc        = pc_q;
    assign hlt       = hlt_q;

    // a write in MEM must be a store that left EX the cycle before
    assert property (@(posedge clk) disable iff (reset) dmem_we |-> $past(ex_opcode == OP_SW))
        else $error("data write from a bubble in MEM");

endmodule

`default_nettype wire

// ==== verification/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// opens a new table row
task automatic begin_test(input string name, input word_t hpc);
    test_name[n_tests] = name;
    halt_pc[n_tests]   = hpc;
    prog_len[n_tests]  = 0;
    init_cnt[n_tests]  = 0;
    exp_cnt[n_tests]   = 0;
    n_tests++;
endtask

// words are packed first-instruction-leftmost
task automatic set_program(input logic [16*MAX_WORDS-1:0] words, input int n);
    int t;
    t = n_tests - 1;
    for (int i = 0; i < n; i++) begin
        prog_word[t][i] = words[(n-1-i)*16 +: 16];
    end
    prog_len[t] = n;
endtask

// pairs of {byte address, value}
task automatic set_data(input logic [32*MAX_STORES-1:0] pairs, input int n);
    int t;
    t = n_tests - 1;
    for (int i = 0; i < n; i++) begin
        init_addr[t][i] = pairs[(n-1-i)*32+16 +: 16];
        init_val[t][i]  = pairs[(n-1-i)*32 +: 16];
    end
    init_cnt[t] = n;
endtask

// expected stores in program order, {byte address, value}
task automatic set_stores(input logic [32*MAX_STORES-1:0] pairs, input int n);
    int t;
    t = n_tests - 1;
    for (int i = 0; i < n; i++) begin
        exp_addr[t][i] = pairs[(n-1-i)*32+16 +: 16];
        exp_data[t][i] = pairs[(n-1-i)*32 +: 16];
    end
    exp_cnt[t] = n;
endtask

task automatic build_tests();
    // 7fff + 1 overflows, branch on V skips the store at 2
    begin_test("arith", 16'h001E);
    set_program({16'hA1FF, 16'hB17F, 16'hA201, 16'h0312, 16'h9300, 16'hCC01,
                 16'h9101, 16'h1421, 16'h9402, 16'h1532, 16'h9503, 16'h2615,
                 16'h9604, 16'h0711, 16'h9705, 16'hF000}, 16);
    set_stores({16'h0000, 16'h8000, 16'h0004, 16'h8002, 16'h0006, 16'h7FFF,
                16'h0008, 16'h0000, 16'h000A, 16'hFFFE}, 5);

    // r1 = 9234 shifted and rotated
    begin_test("shifts", 16'h001C);
    set_program({16'hA134, 16'hB192, 16'h4214, 16'h9200, 16'h5314, 16'h9301,
                 16'h6418, 16'h9402, 16'h551F, 16'h9503, 16'h6610, 16'h9604,
                 16'h471F, 16'h9705, 16'hF000}, 15);
    set_stores({16'h0000, 16'h2340, 16'h0002, 16'hF923, 16'h0004, 16'h3492,
                16'h0006, 16'hFFFF, 16'h0008, 16'h9234, 16'h000A, 16'h0000}, 6);

    begin_test("forwarding", 16'h001A);
    set_program({16'hA105, 16'hA203, 16'h0312, 16'h0433, 16'h1541, 16'h0712,
                 16'h0651, 16'h9600, 16'h9401, 16'h9702, 16'h0867, 16'h9803,
                 16'h9504, 16'hF000}, 14);
    set_stores({16'h0000, 16'h0010, 16'h0002, 16'h0010, 16'h0004, 16'h0008,
                16'h0006, 16'h0018, 16'h0008, 16'h000B}, 5);

    begin_test("load_use", 16'h0012);
    set_program({16'hA110, 16'h8210, 16'h0322, 16'h9300, 16'h8411, 16'h9401,
                 16'h8510, 16'h1645, 16'h9602, 16'hF000}, 10);
    set_data({16'h0010, 16'h1234, 16'h0012, 16'h0101}, 2);
    set_stores({16'h0000, 16'h2468, 16'h0002, 16'h0101, 16'h0004, 16'hEECD}, 3);

    // every skipped slot holds a store of r9 to address 0
    begin_test("branches", 16'h0048);
    set_program({16'hA101, 16'hA202, 16'hA9EE, 16'h1311, 16'hC201, 16'h9900,
                 16'hC001, 16'h9101, 16'hC801, 16'h9900, 16'hCA01, 16'h9900,
                 16'hC401, 16'h9202, 16'hC601, 16'h9103, 16'h1412, 16'hC601,
                 16'h9900, 16'hC401, 16'h9204, 16'hC001, 16'h9900, 16'hCC01,
                 16'h9105, 16'hCE01, 16'h9900, 16'hC801, 16'h9406, 16'h0512,
                 16'hC401, 16'h9900, 16'hC201, 16'h9507, 16'hCA01, 16'h9527,
                 16'hF000}, 37);
    set_stores({16'h0002, 16'h0001, 16'h0004, 16'h0002, 16'h0006, 16'h0001,
                16'h0008, 16'h0002, 16'h000A, 16'h0001, 16'h000C, 16'hFFFF,
                16'h000E, 16'h0003, 16'h0010, 16'h0003}, 8);

    // the store behind the halt is never fetched
    begin_test("halt", 16'h0004);
    set_program({16'hA142, 16'h9100, 16'hF000, 16'h9101}, 4);
    set_stores({16'h0000, 16'h0042}, 1);
endtask

`endif

// ==== verification/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int MAX_TESTS  = 8;
    localparam int MAX_WORDS  = 64;
    localparam int MAX_STORES = 16;
    localparam int TIMEOUT    = 200;

    logic  clk;
    logic  reset;
    word_t imem_rdata;
    word_t dmem_rdata;
    word_t imem_addr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    logic  hlt;
    word_t pc;

    // word-indexed memories
    word_t imem [256];
    word_t dmem [256];

    // test table
    string test_name [MAX_TESTS];
    word_t halt_pc   [MAX_TESTS];
    word_t prog_word [MAX_TESTS][MAX_WORDS];
    int    prog_len  [MAX_TESTS];
    word_t init_addr [MAX_TESTS][MAX_STORES];
    word_t init_val  [MAX_TESTS][MAX_STORES];
    int    init_cnt  [MAX_TESTS];
    word_t exp_addr  [MAX_TESTS][MAX_STORES];
    word_t exp_data  [MAX_TESTS][MAX_STORES];
    int    exp_cnt   [MAX_TESTS];
    int    n_tests;

    // stores seen at the memory
    word_t log_addr [$];
    word_t log_data [$];

    // write port sampled half a cycle before the edge that commits it
    logic  we_s;
    word_t addr_s;
    word_t wdata_s;

    int test_errors;
    int errors;
    int passed;
    int failed;

    `include "tb_programs.svh"

    cpu i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .hlt        (hlt),
        .pc         (pc)
    );

    // combinational reads
    assign imem_rdata = imem[imem_addr[8:1]];
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        we_s    <= dmem_we;
        addr_s  <= dmem_addr;
        wdata_s <= dmem_wdata;
    end

    always @(posedge clk) begin
        if (we_s === 1'b1) begin
            dmem[addr_s[8:1]] <= wdata_s;
            log_addr.push_back(addr_s);
            log_data.push_back(wdata_s);
        end
    end

    // unused imem words decode as halt, low bits carry the index
    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {4'hF, 12'(i)};
            dmem[i] = {8'(i), ~8'(i)};
        end
    endtask

    task automatic load_test(input int t);
        fill_memories();
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = prog_word[t][i];
        end
        for (int i = 0; i < init_cnt[t]; i++) begin
            dmem[init_addr[t][i][8:1]] = init_val[t][i];
        end
    endtask

    task automatic check_stores(input int t);
        int n;
        n = log_addr.size();
        if (n != exp_cnt[t]) begin
            $display("%s: saw %0d stores where %0d were expected", test_name[t], n, exp_cnt[t]);
            test_errors++;
        end
        if (exp_cnt[t] < n) begin
            n = exp_cnt[t];
        end
        for (int i = 0; i < n; i++) begin
            if (log_addr[i] !== exp_addr[t][i]) begin
                $display("ERROR %0t: dmem_addr = %h, expected %h", $time,
                         log_addr[i], exp_addr[t][i]);
                test_errors++;
            end
            if (log_data[i] !== exp_data[t][i]) begin
                $display("ERROR %0t: dmem_wdata = %h, expected %h", $time,
                         log_data[i], exp_data[t][i]);
                test_errors++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int    cycles;
        word_t hpc;
        test_errors = 0;
        reset = 1'b1;
        load_test(t);
        log_addr.delete();
        log_data.delete();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (hlt !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (hlt !== 1'b1) begin
            $display("%s: hlt did not rise within %0d cycles", test_name[t], TIMEOUT);
            test_errors++;
        end else begin
            hpc = pc;
            if (hpc !== halt_pc[t]) begin
                $display("ERROR %0t: pc = %h, expected %h", $time, hpc, halt_pc[t]);
                test_errors++;
            end
            // fetch must stay parked on the halt
            for (int i = 0; i < 10; i++) begin
                @(negedge clk);
                if (pc !== halt_pc[t]) begin
                    $display("ERROR %0t: pc = %h, expected %h", $time, pc, halt_pc[t]);
                    test_errors++;
                end
            end
            check_stores(t);
        end
        if (test_errors == 0) begin
            $display("%s: pass", test_name[t]);
            passed++;
        end else begin
            $display("%s: fail with %0d errors", test_name[t], test_errors);
            failed++;
        end
        errors += test_errors;
    endtask

    initial begin
        reset   = 1'b1;
        errors  = 0;
        passed  = 0;
        failed  = 0;
        n_tests = 0;
        fill_memories();
        build_tests();
        @(negedge clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
+incdir+verification
logic/cpu_pkg.sv
logic/instr_decode.sv
logic/branch_control.sv
logic/register_file.sv
logic/alu.sv
logic/hazard_unit.sv
logic/cpu.sv
verification/tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - target: any(rtl, test)
    include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/instr_decode.sv
      - logic/branch_control.sv
      - logic/register_file.sv
      - logic/alu.sv
      - logic/hazard_unit.sv
      - logic/cpu.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cpu.sv
